// File: hps_pkg.sv
// shared widths, host command codes and keyboard sequence constants; imported by the bridge blocks

package hps_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	// one host bus word
	localparam int WORD_W       = 16;

	// saturating data word index within a frame
	localparam int WIDX_W       = 10;

	// characters in the configuration string of this build
	localparam int CONF_STRLEN  = 8;

	// download address and data item
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 8;

	// keyboard event word {toggle, pressed, extended, code}
	localparam int KEY_W        = 11;

	//////////////////////////////////////////////////
	// host command codes
	//////////////////////////////////////////////////

	// control registers
	localparam logic [WORD_W-1:0] CMD_CFG         = 16'h0001;
	localparam logic [WORD_W-1:0] CMD_JOY0        = 16'h0002;
	localparam logic [WORD_W-1:0] CMD_JOY1        = 16'h0003;
	localparam logic [WORD_W-1:0] CMD_KBD         = 16'h0005;
	localparam logic [WORD_W-1:0] CMD_CONF_STR    = 16'h0014;
	localparam logic [WORD_W-1:0] CMD_JOY_ANALOG  = 16'h001A;
	localparam logic [WORD_W-1:0] CMD_STATUS      = 16'h001E;

	// file download
	localparam logic [WORD_W-1:0] CMD_FILE_TX     = 16'h0053;
	localparam logic [WORD_W-1:0] CMD_FILE_TX_DAT = 16'h0054;
	localparam logic [WORD_W-1:0] CMD_FILE_INDEX  = 16'h0055;
	localparam logic [WORD_W-1:0] CMD_FILE_INFO   = 16'h0056;

	//////////////////////////////////////////////////
	// keyboard special sequences
	//////////////////////////////////////////////////

	// newest byte sits in bits 7:0 of the history
	localparam logic [31:0] KEY_PRNSCR_MAKE  = 32'hE012_E07C;
	localparam logic [31:0] KEY_PRNSCR_BREAK = 32'h7CE0_F012;

	// last four bytes of the pause sequence
	// pause sends no break code
	localparam logic [31:0] KEY_PAUSE_MAKE   = 32'hF014_F077;

	// replacement {pressed, extended, code} for the sequences above
	localparam logic [9:0]  KEY_PRNSCR_CODE  = 10'h37C;
	localparam logic [9:0]  KEY_PAUSE_CODE   = 10'h377;

	// scancode prefixes
	localparam logic [7:0]  KEY_BREAK_PREFIX = 8'hF0;
	localparam logic [7:0]  KEY_EXT_PREFIX   = 8'hE0;

endpackage

// File: hps_cmd_frame.sv
// host frame tracker; latches the command word, numbers the data words and flags the frame end
`timescale 1ns/1ps

module hps_cmd_frame (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic                       io_enable,
	input  logic                       io_strobe,
	input  logic [hps_pkg::WORD_W-1:0] io_din,
	output logic [hps_pkg::WORD_W-1:0] cmd,
	output logic [hps_pkg::WIDX_W-1:0] word_idx,
	output logic                       data_stb,
	output logic                       frame_end
);
	import hps_pkg::*;

	// set by the first strobe of a frame
	logic have_cmd;
	logic enable_d;

	//////////////////////////////////////////////////
	// command latch and word counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			have_cmd <= 1'b0;
			cmd      <= '0;
			word_idx <= '0;
		end else if (!io_enable) begin
			have_cmd <= 1'b0;
			word_idx <= '0;
			// keep the command through the frame_end cycle
			if (!enable_d)
				cmd <= '0;
		end else if (io_strobe) begin
			if (!have_cmd) begin
				have_cmd <= 1'b1;
				cmd      <= io_din;
				// the next strobe is data word 1
				word_idx <= WIDX_W'(1);
			end else if (~&word_idx) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	// every strobe after the command word
	assign data_stb = io_enable & io_strobe & have_cmd;

	//////////////////////////////////////////////////
	// end of frame
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			enable_d  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			enable_d  <= io_enable;
			frame_end <= enable_d & ~io_enable;
		end
	end

endmodule

// File: hps_ctrl_regs.sv
// control register block for buttons, joysticks and status, with configuration string readback
`timescale 1ns/1ps

module hps_ctrl_regs (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  logic                              io_enable,
	input  logic [hps_pkg::WORD_W-1:0]        cmd,
	input  logic [hps_pkg::WIDX_W-1:0]        word_idx,
	input  logic                              data_stb,
	input  logic [hps_pkg::WORD_W-1:0]        io_din,
	input  logic [8*hps_pkg::CONF_STRLEN-1:0] conf_str,
	output logic [hps_pkg::WORD_W-1:0]        io_dout,
	output logic [1:0]                        buttons,
	output logic                              forced_scandoubler,
	output logic [hps_pkg::WORD_W-1:0]        joystick_0,
	output logic [hps_pkg::WORD_W-1:0]        joystick_1,
	output logic [hps_pkg::WORD_W-1:0]        joystick_analog_0,
	output logic [hps_pkg::WORD_W-1:0]        joystick_analog_1,
	output logic [31:0]                       status
);
	import hps_pkg::*;

	// analog stick chosen by word 1 with one bit per stick
	logic [1:0] stick_sel;

	// byte position of the requested character with the first character on top
	logic [WIDX_W-1:0] char_pos;

	assign char_pos = WIDX_W'(CONF_STRLEN) - word_idx;

	//////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			joystick_analog_0  <= '0;
			joystick_analog_1  <= '0;
			status             <= '0;
			stick_sel          <= '0;
		end else if (data_stb) begin
			case (cmd)
				CMD_CFG: begin
					// bits 2, 3 and 5 belong to the system top
					buttons            <= io_din[1:0];
					forced_scandoubler <= io_din[4];
				end
				CMD_JOY0: joystick_0 <= io_din;
				CMD_JOY1: joystick_1 <= io_din;
				CMD_JOY_ANALOG: begin
					if (word_idx == WIDX_W'(1)) begin
						stick_sel[0] <= (io_din == WORD_W'(0));
						stick_sel[1] <= (io_din == WORD_W'(1));
					end
					if (word_idx == WIDX_W'(2)) begin
						if (stick_sel[0])
							joystick_analog_0 <= io_din;
						if (stick_sel[1])
							joystick_analog_1 <= io_din;
					end
				end
				CMD_STATUS: begin
					// low half first
					if (word_idx == WIDX_W'(1))
						status[15:0] <= io_din;
					else if (word_idx == WIDX_W'(2))
						status[31:16] <= io_din;
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// readback
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (data_stb) begin
			io_dout <= '0;
			if (cmd == CMD_CONF_STR && word_idx <= WIDX_W'(CONF_STRLEN))
				io_dout[7:0] <= conf_str[char_pos*8 +: 8];
		end
	end

endmodule

// File: hps_file_loader.sv
// file download control; turns host download frames into indexed byte writes for the core
`timescale 1ns/1ps

module hps_file_loader (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic [hps_pkg::WORD_W-1:0]       cmd,
	input  logic [hps_pkg::WIDX_W-1:0]       word_idx,
	input  logic                             data_stb,
	input  logic [hps_pkg::WORD_W-1:0]       io_din,
	output logic                             ioctl_download,
	output logic [7:0]                       ioctl_index,
	output logic [31:0]                      ioctl_file_ext,
	output logic [hps_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	output logic [hps_pkg::IOCTL_DATA_W-1:0] ioctl_dout,
	output logic                             ioctl_wr
);
	import hps_pkg::*;

	// next byte address and also the count of bytes written so far
	logic [IOCTL_ADDR_W-1:0] addr;

	// first stage of the write pulse
	logic wr_req;

	//////////////////////////////////////////////////
	// download control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			addr           <= '0;
			wr_req         <= 1'b0;
		end else begin
			wr_req <= 1'b0;
			if (data_stb) begin
				case (cmd)
					CMD_FILE_INFO: begin
						// extension arrives upper half first
						if (word_idx == WIDX_W'(1))
							ioctl_file_ext[31:16] <= io_din;
						else if (word_idx == WIDX_W'(2))
							ioctl_file_ext[15:0] <= io_din;
					end
					CMD_FILE_INDEX: ioctl_index <= io_din[7:0];
					CMD_FILE_TX: begin
						if (io_din[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final byte count
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[IOCTL_DATA_W-1:0];
						wr_req     <= 1'b1;
						addr       <= addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// write strobe
	//////////////////////////////////////////////////

	// address and data settle one cycle ahead of the pulse
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ioctl_wr <= 1'b0;
		else
			ioctl_wr <= wr_req;
	end

endmodule

// File: hps_kbd_decoder.sv
// keyboard event decoder; folds the scancode bytes of a frame into the ps2_key event word
`timescale 1ns/1ps

module hps_kbd_decoder (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  logic [hps_pkg::WORD_W-1:0] cmd,
	input  logic [hps_pkg::WIDX_W-1:0] word_idx,
	input  logic                       data_stb,
	input  logic                       frame_end,
	input  logic [hps_pkg::WORD_W-1:0] io_din,
	output logic [hps_pkg::KEY_W-1:0]  ps2_key
);
	import hps_pkg::*;

	// last four scancode bytes with the newest in the low byte
	logic [31:0] key_raw;
	// frame holds a word that is not a scancode
	logic        skip;
	logic        no_code;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	assign no_code = &io_din[WORD_W-1:8];

	//////////////////////////////////////////////////
	// byte history
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_raw <= '0;
			skip    <= 1'b0;
		end else if (data_stb && cmd == CMD_KBD) begin
			if (word_idx == WIDX_W'(1)) begin
				// new frame starts from an empty history
				skip    <= no_code;
				key_raw <= no_code ? 32'h0 : {24'h0, io_din[7:0]};
			end else if (no_code) begin
				skip <= 1'b1;
			end else if (!skip) begin
				key_raw <= {key_raw[23:0], io_din[7:0]};
			end
		end
	end

	//////////////////////////////////////////////////
	// event word
	//////////////////////////////////////////////////

	assign pressed  = (key_raw[15:8] != KEY_BREAK_PREFIX);
	// a break code pushes the E0 prefix one byte further back
	assign extended = pressed ? (key_raw[15:8] == KEY_EXT_PREFIX) :
	                            (key_raw[23:16] == KEY_EXT_PREFIX);

	always_comb begin
		key_code = {pressed, extended, key_raw[7:0]};
		if (key_raw == KEY_PRNSCR_MAKE)
			key_code = KEY_PRNSCR_CODE;
		else if (key_raw == KEY_PRNSCR_BREAK)
			key_code = {1'b0, KEY_PRNSCR_CODE[8:0]};
		else if (key_raw == KEY_PAUSE_MAKE)
			key_code = KEY_PAUSE_CODE;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ps2_key <= '0;
		else if (frame_end && cmd == CMD_KBD && !skip)
			ps2_key <= {~ps2_key[KEY_W-1], key_code};
	end

endmodule

// File: hps_io.sv
// top of the host-to-core command bridge; connects the frame tracker to the function blocks
`timescale 1ns/1ps

module hps_io (
	input  logic                              clk_sys,
	input  logic                              arst_n,

	// host bus
	input  logic                              io_enable,
	input  logic                              io_strobe,
	input  logic [hps_pkg::WORD_W-1:0]        io_din,
	output logic [hps_pkg::WORD_W-1:0]        io_dout,
	output logic                              io_wait,

	input  logic [8*hps_pkg::CONF_STRLEN-1:0] conf_str,

	// control registers
	output logic [1:0]                        buttons,
	output logic                              forced_scandoubler,
	output logic [hps_pkg::WORD_W-1:0]        joystick_0,
	output logic [hps_pkg::WORD_W-1:0]        joystick_1,
	output logic [hps_pkg::WORD_W-1:0]        joystick_analog_0,
	output logic [hps_pkg::WORD_W-1:0]        joystick_analog_1,
	output logic [31:0]                       status,

	// download to the core
	output logic                              ioctl_download,
	output logic [7:0]                        ioctl_index,
	output logic [31:0]                       ioctl_file_ext,
	output logic [hps_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	output logic [hps_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	output logic                              ioctl_wr,
	input  logic                              ioctl_wait,

	// {toggle, pressed, extended, code}
	output logic [hps_pkg::KEY_W-1:0]         ps2_key
);
	import hps_pkg::*;

	logic [WORD_W-1:0] cmd;
	logic [WIDX_W-1:0] word_idx;
	logic              data_stb;
	logic              frame_end;

	// the host polls this to pace the download
	assign io_wait = ioctl_wait;

	hps_cmd_frame u_frame (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.cmd       (cmd),
		.word_idx  (word_idx),
		.data_stb  (data_stb),
		.frame_end (frame_end)
	);

	hps_ctrl_regs u_regs (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.data_stb           (data_stb),
		.io_din             (io_din),
		.conf_str           (conf_str),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_analog_0  (joystick_analog_0),
		.joystick_analog_1  (joystick_analog_1),
		.status             (status)
	);

	hps_file_loader u_loader (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.cmd            (cmd),
		.word_idx       (word_idx),
		.data_stb       (data_stb),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr)
	);

	hps_kbd_decoder u_kbd (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cmd       (cmd),
		.word_idx  (word_idx),
		.data_stb  (data_stb),
		.frame_end (frame_end),
		.io_din    (io_din),
		.ps2_key   (ps2_key)
	);

endmodule

// File: tb_clk_gen.sv
// clock and reset source for the bridge testbench; instantiate once in the testbench top
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_sys,
	output logic arst_n
);

	// 10 ns period
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// reset held low for two clock cycles
	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		arst_n <= 1'b1;
	end

endmodule

// File: tb_hps_io.sv
// directed testbench for the host-to-core bridge; runs every test and reports the overall result
`timescale 1ns/1ps

module tb_hps_io;
	import hps_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int DL_WORDS   = 12;
	localparam logic [8*CONF_STRLEN-1:0] CONF_BITS = "TESTCORE";

	logic                    clk_sys;
	logic                    arst_n;
	logic                    io_enable;
	logic                    io_strobe;
	logic [WORD_W-1:0]       io_din;
	logic                    ioctl_wait;
	logic [WORD_W-1:0]       io_dout;
	logic                    io_wait;
	logic [1:0]              buttons;
	logic                    forced_scandoubler;
	logic [WORD_W-1:0]       joystick_0;
	logic [WORD_W-1:0]       joystick_1;
	logic [WORD_W-1:0]       joystick_analog_0;
	logic [WORD_W-1:0]       joystick_analog_1;
	logic [31:0]             status;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	logic [31:0]             ioctl_file_ext;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [IOCTL_DATA_W-1:0] ioctl_dout;
	logic                    ioctl_wr;
	logic [KEY_W-1:0]        ps2_key;

	string conf_chars = "TESTCORE";
	string cur_test;
	int    err_count;
	int    test_errs;
	int    tests_run;
	int    tests_failed;
	int unsigned seed_val;

	// write pulses seen on the download port
	logic [IOCTL_ADDR_W-1:0] wr_addr_q[$];
	logic [IOCTL_DATA_W-1:0] wr_data_q[$];

	tb_clk_gen u_clk_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	hps_io u_hps_io (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.io_wait            (io_wait),
		.conf_str           (CONF_BITS),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_analog_0  (joystick_analog_0),
		.joystick_analog_1  (joystick_analog_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wr           (ioctl_wr),
		.ioctl_wait         (ioctl_wait),
		.ps2_key            (ps2_key)
	);

	// values sampled at the edge that ends the write pulse
	always @(posedge clk_sys) begin
		if (ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	//////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////

	task automatic test_begin(input string name);
		cur_test  = name;
		test_errs = err_count;
	endtask

	task automatic test_end();
		tests_run++;
		if (err_count == test_errs) begin
			$display("test %s: passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, err_count - test_errs);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout in test %s while waiting for %s", cur_test, what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s %s expected %b actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_word(input string what, input logic [WORD_W-1:0] exp,
	                          input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_key(input string what, input logic [KEY_W-1:0] exp,
	                         input logic [KEY_W-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_addr(input string what, input logic [IOCTL_ADDR_W-1:0] exp,
	                          input logic [IOCTL_ADDR_W-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_byte(input string what, input logic [IOCTL_DATA_W-1:0] exp,
	                          input logic [IOCTL_DATA_W-1:0] act);
		if (act !== exp) begin
			err_count++;
			$display("ERROR %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// host bus
	//////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic frame_begin();
		@(posedge clk_sys);
		io_enable <= 1'b1;
	endtask

	task automatic send_word(input logic [WORD_W-1:0] w);
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din    <= w;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		wait_cycles(3);
	endtask

	task automatic frame_finish();
		@(posedge clk_sys);
		io_enable <= 1'b0;
		wait_cycles(3);
	endtask

	// command followed by one or two data words
	task automatic host_write(input logic [WORD_W-1:0] c, input logic [WORD_W-1:0] w1,
	                          input logic [WORD_W-1:0] w2, input int n);
		frame_begin();
		send_word(c);
		send_word(w1);
		if (n > 1)
			send_word(w2);
		frame_finish();
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_registers();
		logic [WORD_W-1:0] j0;
		logic [WORD_W-1:0] j1;
		logic [WORD_W-1:0] a0;
		logic [WORD_W-1:0] a1;
		logic [31:0]       st;
		test_begin("registers");
		j0 = WORD_W'($urandom);
		j1 = WORD_W'($urandom);
		a0 = WORD_W'($urandom);
		a1 = WORD_W'($urandom);
		st = $urandom;
		host_write(CMD_JOY0, j0, '0, 1);
		host_write(CMD_JOY1, j1, '0, 1);
		host_write(CMD_STATUS, st[15:0], st[31:16], 2);
		host_write(CMD_JOY_ANALOG, 16'd0, a0, 2);
		host_write(CMD_JOY_ANALOG, 16'd1, a1, 2);
		check_word("joystick_0", j0, joystick_0);
		check_word("joystick_1", j1, joystick_1);
		check_word("status low", st[15:0], status[15:0]);
		check_word("status high", st[31:16], status[31:16]);
		check_word("joystick_analog_0", a0, joystick_analog_0);
		check_word("joystick_analog_1", a1, joystick_analog_1);
		// stick 5 does not exist
		host_write(CMD_JOY_ANALOG, 16'd5, WORD_W'($urandom), 2);
		check_word("analog_0 after index 5", a0, joystick_analog_0);
		check_word("analog_1 after index 5", a1, joystick_analog_1);
		test_end();
	endtask

	task automatic test_config();
		logic [WORD_W-1:0] w;
		test_begin("config");
		w = WORD_W'($urandom);
		host_write(CMD_CFG, w, '0, 1);
		check_byte("buttons and scandoubler", {5'b0, w[4], w[1:0]},
		           {5'b0, forced_scandoubler, buttons});
		// the inverted word flips every checked bit
		w = ~w;
		host_write(CMD_CFG, w, '0, 1);
		check_byte("inverted buttons and scandoubler", {5'b0, w[4], w[1:0]},
		           {5'b0, forced_scandoubler, buttons});
		test_end();
	endtask

	task automatic test_conf_str();
		logic [WORD_W-1:0] exp;
		test_begin("conf_str");
		frame_begin();
		send_word(CMD_CONF_STR);
		for (int k = 1; k <= CONF_STRLEN + 2; k++) begin
			send_word('0);
			exp = '0;
			if (k <= CONF_STRLEN)
				exp[7:0] = conf_chars[k-1];
			check_word($sformatf("char %0d", k), exp, io_dout);
		end
		frame_finish();
		// end a frame while a character is still on io_dout
		frame_begin();
		send_word(CMD_CONF_STR);
		send_word('0);
		exp = '0;
		exp[7:0] = conf_chars[0];
		check_word("char 1 again", exp, io_dout);
		frame_finish();
		check_word("io_dout after frame", '0, io_dout);
		test_end();
	endtask

	task automatic test_wait_flag();
		test_begin("io_wait");
		@(posedge clk_sys);
		ioctl_wait <= 1'b1;
		@(posedge clk_sys);
		check_bit("io_wait high", 1'b1, io_wait);
		ioctl_wait <= 1'b0;
		@(posedge clk_sys);
		check_bit("io_wait low", 1'b0, io_wait);
		test_end();
	endtask

	task automatic test_download();
		logic [7:0]              idx;
		logic [31:0]             ext;
		logic [WORD_W-1:0]       w;
		logic [IOCTL_DATA_W-1:0] sent[$];
		int                      t;
		test_begin("download");
		idx = 8'($urandom);
		ext = $urandom;
		host_write(CMD_FILE_INDEX, {8'h00, idx}, '0, 1);
		host_write(CMD_FILE_INFO, ext[31:16], ext[15:0], 2);
		host_write(CMD_FILE_TX, 16'h00FF, '0, 1);
		t = 0;
		while (!ioctl_download && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (!ioctl_download)
			abort_run("ioctl_download to rise");
		wr_addr_q.delete();
		wr_data_q.delete();
		frame_begin();
		send_word(CMD_FILE_TX_DAT);
		for (int k = 0; k < DL_WORDS; k++) begin
			w = WORD_W'($urandom);
			sent.push_back(w[7:0]);
			send_word(w);
		end
		frame_finish();
		t = 0;
		while (wr_addr_q.size() < DL_WORDS && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (wr_addr_q.size() < DL_WORDS)
			abort_run("the ioctl_wr pulses");
		check_addr("write count", IOCTL_ADDR_W'(DL_WORDS), IOCTL_ADDR_W'(wr_addr_q.size()));
		for (int k = 0; k < DL_WORDS; k++) begin
			check_addr($sformatf("addr %0d", k), IOCTL_ADDR_W'(k), wr_addr_q[k]);
			check_byte($sformatf("data %0d", k), sent[k], wr_data_q[k]);
		end
		host_write(CMD_FILE_TX, 16'h0000, '0, 1);
		t = 0;
		while (ioctl_download && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (ioctl_download)
			abort_run("ioctl_download to fall");
		check_addr("final addr", IOCTL_ADDR_W'(DL_WORDS), ioctl_addr);
		check_byte("index", idx, ioctl_index);
		check_word("ext high", ext[31:16], ioctl_file_ext[31:16]);
		check_word("ext low", ext[15:0], ioctl_file_ext[15:0]);
		test_end();
	endtask

	// seq holds n bytes with the first byte sent in the highest used byte
	task automatic kbd_frame(input string what, input logic [63:0] seq, input int n,
	                         input logic bad_word, input logic [9:0] exp_code,
	                         inout logic [KEY_W-1:0] exp_key);
		frame_begin();
		send_word(CMD_KBD);
		for (int i = n - 1; i >= 0; i--)
			send_word({8'h00, seq[8*i +: 8]});
		if (bad_word)
			send_word(16'hFF00);
		frame_finish();
		// a skipped frame leaves the event word alone
		if (!bad_word)
			exp_key = {~exp_key[KEY_W-1], exp_code};
		check_key(what, exp_key, ps2_key);
	endtask

	task automatic test_keyboard();
		logic [KEY_W-1:0] exp_key;
		logic [7:0]       b;
		test_begin("keyboard");
		// no keyboard frame since reset
		exp_key = '0;
		b = 8'($urandom_range(8'h7F, 8'h01));
		// expected code is {pressed, extended, scancode}
		kbd_frame("make", {56'h0, b}, 1, 1'b0, {2'b10, b}, exp_key);
		kbd_frame("extended make", 64'hE075, 2, 1'b0, 10'h375, exp_key);
		kbd_frame("break", 64'hF01C, 2, 1'b0, 10'h01C, exp_key);
		kbd_frame("extended break", 64'hE0F075, 3, 1'b0, 10'h175, exp_key);
		kbd_frame("prnscr make", 64'hE012E07C, 4, 1'b0, KEY_PRNSCR_CODE, exp_key);
		kbd_frame("prnscr break", 64'hE0F07CE0F012, 6, 1'b0, 10'h17C, exp_key);
		kbd_frame("pause", 64'hE11477E1F014F077, 8, 1'b0, KEY_PAUSE_CODE, exp_key);
		kbd_frame("skipped frame", 64'h1C, 1, 1'b1, 10'h000, exp_key);
		test_end();
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int t;
		io_enable    = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		ioctl_wait   = 1'b0;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		cur_test     = "reset";
		seed_val     = $urandom(32'h4690de68);
		t = 0;
		while (arst_n !== 1'b1 && t < WAIT_LIMIT) begin
			@(posedge clk_sys);
			t++;
		end
		if (arst_n !== 1'b1)
			abort_run("reset release");
		wait_cycles(2);
		test_registers();
		test_config();
		test_conf_str();
		test_wait_flag();
		test_download();
		test_keyboard();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
		if (err_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: flist.f
hps_pkg.sv
hps_cmd_frame.sv
hps_ctrl_regs.sv
hps_file_loader.sv
hps_kbd_decoder.sv
hps_io.sv
tb_clk_gen.sv
tb_hps_io.sv
